/* haar_pkg.sv */
`default_nettype none

package haar_pkg;

	//////////////////////////////
	// Datapath widths
	//////////////////////////////

	typedef logic [15:0] pixel_t;          // Integral-image sample, always non-negative
	typedef logic signed [15:0] weight_t;  // Rectangle weight, tree threshold or leaf word
	typedef logic signed [31:0] feature_t; // Weighted feature total or running vote sum
	typedef logic [11:0] corner_t;         // Linear address into the window

	//////////////////////////////
	// Classifier sequencing
	//////////////////////////////

	typedef enum logic [2:0]
	{
		IDLE,   // Waiting for start
		LOAD,   // Taking database words off the stream
		FETCH,  // Reading the twelve corners from the window
		CALC,   // Forming the weighted feature total
		VOTE,   // Adding the left or right word to the vote sum
		DECIDE  // Comparing the vote sum with the stage threshold
	} class_state_t;

endpackage

`default_nettype wire

/* haar_bus_pkg.sv */
`default_nettype none

package haar_bus_pkg;

	typedef logic [11:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// Region bases, decoded on address bits 11:8
	localparam wb_addr_t WIN_BASE = 12'h000;
	localparam wb_addr_t DB_BASE = 12'h100;
	localparam wb_addr_t REG_BASE = 12'h200;

	typedef enum logic [1:0]
	{
		REG_CTRL = 2'd0,   // Bit 0 starts a run
		REG_STATUS = 2'd1, // Busy, done and candidate
		REG_SUM = 2'd2     // Final vote sum
	} reg_sel_t;

	// Word positions inside one tree record
	typedef enum logic [4:0]
	{
		RECT1_A, RECT1_B, RECT1_C, RECT1_D, WEIGHT1,
		RECT2_A, RECT2_B, RECT2_C, RECT2_D, WEIGHT2,
		RECT3_A, RECT3_B, RECT3_C, RECT3_D, WEIGHT3,
		TREE_THRESH, LEFT_WORD, RIGHT_WORD
	} db_word_t;

	localparam int TREE_WORDS = 18;

endpackage

`default_nettype wire

/* haar_db_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface db_haar_if;

	logic word_valid;                // A word is on the stream this cycle
	logic [15:0] word;
	haar_bus_pkg::db_word_t word_pos; // Position inside the tree record
	logic stage_word;                // Word is the stage threshold
	logic tree_last;                 // Last word of a tree
	logic stage_last;                // Last word of the whole stage
	logic hold;                      // Classifier is busy with a tree

	modport seq (output word_valid, word, word_pos, stage_word, tree_last, stage_last,
		input hold);
	modport cls (input word_valid, word, word_pos, stage_word, tree_last, stage_last,
		output hold);

endinterface

`default_nettype wire

/* haar_wb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module haar_wb_regs
(
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input haar_bus_pkg::wb_addr_t wb_adr,
	input haar_bus_pkg::wb_data_t wb_dat_w,
	input logic busy,
	input logic done,
	input logic candidate,
	input haar_pkg::feature_t vote_sum,
	input haar_pkg::pixel_t win_rdata,
	output haar_bus_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	output logic win_we,
	output haar_pkg::corner_t win_waddr,
	output haar_pkg::pixel_t win_wdata,
	output logic db_we,
	output logic [7:0] db_waddr,
	output logic [15:0] db_wdata,
	output logic start
);

	logic req;
	logic wr_stb;
	logic win_hit;
	logic db_hit;
	logic reg_hit;
	haar_bus_pkg::reg_sel_t reg_sel;
	logic done_q;
	logic cand_q;

	//////////////////////////////
	// Decode
	//////////////////////////////

	assign req = wb_cyc && wb_stb;
	assign wr_stb = req && wb_we && !wb_ack; // Commits on the edge that raises ack

	assign win_hit = (wb_adr & 12'hF00) == haar_bus_pkg::WIN_BASE;
	assign db_hit = (wb_adr & 12'hF00) == haar_bus_pkg::DB_BASE;
	assign reg_hit = (wb_adr & 12'hF00) == haar_bus_pkg::REG_BASE;
	assign reg_sel = haar_bus_pkg::reg_sel_t'(wb_adr[1:0]);

	// Window address also drives the host side of the shared read port
	assign win_we = wr_stb && win_hit;
	assign win_waddr = haar_pkg::corner_t'(wb_adr & 12'h0FF);
	assign win_wdata = wb_dat_w[15:0];

	assign db_we = wr_stb && db_hit;
	assign db_waddr = wb_adr[7:0];
	assign db_wdata = wb_dat_w[15:0];

	assign start = wr_stb && reg_hit && (reg_sel == haar_bus_pkg::REG_CTRL) && wb_dat_w[0]
		&& !busy; // A start during a run is dropped

	//////////////////////////////
	// Acknowledge and status
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_ack <= 1'b0;
			done_q <= 1'b0;
			cand_q <= 1'b0;
		end
		else
		begin
			wb_ack <= req && !wb_ack; // One wait state, then a single ack cycle
			if (start)
			begin
				done_q <= 1'b0;
				cand_q <= 1'b0;
			end
			else if (done)
			begin
				done_q <= 1'b1;      // Sticky until the next start
				cand_q <= candidate; // Classifier result is valid during the done pulse
			end
		end
	end

	// Read data is taken while ack is high, the master still holds the address
	always_comb
	begin
		wb_dat_r = '0;
		if (win_hit)
			wb_dat_r = haar_bus_pkg::wb_data_t'(win_rdata);
		else if (reg_hit)
		begin
			case (reg_sel)
				haar_bus_pkg::REG_STATUS: wb_dat_r = {29'd0, cand_q, done_q, busy};
				haar_bus_pkg::REG_SUM: wb_dat_r = haar_bus_pkg::wb_data_t'(vote_sum);
				default: wb_dat_r = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* integral_window.sv */
`timescale 1ns/10ps
`default_nettype none

module integral_window
#(
	parameter int WIN_WIDTH = 10,
	parameter int WIN_HEIGHT = 10
)
(
	input logic clk,
	input logic we,
	input haar_pkg::corner_t waddr,
	input haar_pkg::pixel_t wdata,
	input haar_pkg::corner_t raddr,
	output haar_pkg::pixel_t rdata
);

	localparam int WIN_SIZE = WIN_WIDTH * WIN_HEIGHT;
	localparam int AW = $clog2(WIN_SIZE);

	haar_pkg::pixel_t mem [WIN_SIZE];

	// Host write port
	always_ff @(posedge clk)
	begin
		if (we && (waddr < WIN_SIZE))
			mem[waddr[AW-1:0]] <= wdata;
	end

	// Read port shared by host and classifier, one cycle of latency
	always_ff @(posedge clk)
	begin
		if (raddr < WIN_SIZE)
			rdata <= mem[raddr[AW-1:0]];
		else
			rdata <= '0; // Outside the window reads as zero
	end

endmodule

`default_nettype wire

/* db_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module db_sequencer
#(
	parameter int MAX_TREES = 12
)
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic db_we,
	input logic [7:0] db_waddr,
	input logic [15:0] db_wdata,
	db_haar_if.seq db,
	output logic busy
);

	localparam int DB_DEPTH = 2 + MAX_TREES * haar_bus_pkg::TREE_WORDS;
	localparam int DB_AW = $clog2(DB_DEPTH);
	localparam int TW = $clog2(MAX_TREES + 1);
	localparam logic [4:0] LAST_IDX = 5'(haar_bus_pkg::TREE_WORDS - 1);

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_COUNT,
		S_TREE,
		S_WAIT,
		S_DONE
	} seq_state_t;

	logic [15:0] db_mem [DB_DEPTH];
	logic [15:0] rd_word;
	logic [7:0] rd_addr;
	logic [7:0] tree_addr;
	logic [4:0] word_idx;
	logic last_word;
	logic [TW-1:0] trees_left;
	logic [TW-1:0] count_clamped;
	seq_state_t state;
	logic valid_q;
	logic stage_q;
	logic tree_last_q;
	logic stage_last_q;
	haar_bus_pkg::db_word_t pos_q;

	assign db.word_valid = valid_q;
	assign db.word = rd_word;
	assign db.word_pos = pos_q;
	assign db.stage_word = stage_q;
	assign db.tree_last = tree_last_q;
	assign db.stage_last = stage_last_q;

	//////////////////////////////
	// Database storage
	//////////////////////////////

	// Word 0 is the stage threshold, word 1 the tree count, tree records follow
	always_comb
	begin
		case (state)
			S_IDLE: rd_addr = 8'd1;  // Count is read first so the stage word knows it is last
			S_COUNT: rd_addr = 8'd0;
			default: rd_addr = tree_addr;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (db_we && (db_waddr < DB_DEPTH))
			db_mem[db_waddr[DB_AW-1:0]] <= db_wdata;
		if (!db.hold)
			rd_word <= db_mem[rd_addr[DB_AW-1:0]]; // Frozen word stays on the stream
	end

	assign count_clamped = (rd_word > MAX_TREES) ? TW'(MAX_TREES) : rd_word[TW-1:0];
	assign last_word = word_idx == LAST_IDX;

	//////////////////////////////
	// Walker
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			busy <= 1'b0;
			valid_q <= 1'b0;
			stage_q <= 1'b0;
			tree_last_q <= 1'b0;
			stage_last_q <= 1'b0;
			pos_q <= haar_bus_pkg::RECT1_A;
			word_idx <= '0;
			trees_left <= '0;
			tree_addr <= '0;
		end
		else if (!db.hold)
		begin
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						busy <= 1'b1;
						state <= S_COUNT;
					end
				end
				S_COUNT:
				begin
					valid_q <= 1'b1; // Stage threshold goes out next cycle
					stage_q <= 1'b1;
					pos_q <= haar_bus_pkg::RECT1_A;
					tree_last_q <= 1'b0;
					stage_last_q <= count_clamped == '0;
					trees_left <= count_clamped;
					word_idx <= '0;
					tree_addr <= 8'd2;
					state <= (count_clamped == '0) ? S_WAIT : S_TREE;
				end
				S_TREE:
				begin
					valid_q <= 1'b1;
					stage_q <= 1'b0;
					pos_q <= haar_bus_pkg::db_word_t'(word_idx);
					tree_last_q <= last_word;
					stage_last_q <= last_word && (trees_left == TW'(1));
					tree_addr <= tree_addr + 8'd1;
					if (last_word)
					begin
						word_idx <= '0;
						trees_left <= trees_left - TW'(1);
						if (trees_left == TW'(1))
							state <= S_WAIT;
					end
					else
						word_idx <= word_idx + 5'd1;
				end
				S_WAIT:
				begin
					if (valid_q)
					begin
						valid_q <= 1'b0; // Final word taken, stream goes quiet
						stage_q <= 1'b0;
						tree_last_q <= 1'b0;
						stage_last_q <= 1'b0;
					end
					else
						state <= S_DONE; // Hold released, classifier is deciding
				end
				S_DONE:
				begin
					busy <= 1'b0; // Classifier pulses done in this cycle
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* haar_stage_classifier.sv */
`timescale 1ns/10ps
`default_nettype none

module haar_stage_classifier
(
	input logic clk,
	input logic rst_n,
	input logic start,
	db_haar_if.cls db,
	output haar_pkg::corner_t win_raddr,
	input haar_pkg::pixel_t win_rdata,
	output logic done,
	output logic candidate,
	output haar_pkg::feature_t vote_sum
);

	haar_pkg::class_state_t state;
	logic accept;
	logic last_tree;
	logic [3:0] fetch_idx;
	logic [4:0] rec_idx;
	logic [15:0] rec [haar_bus_pkg::TREE_WORDS];
	haar_pkg::pixel_t corner_val [12];
	haar_pkg::weight_t stage_thr;
	haar_pkg::feature_t feat_sum;
	haar_pkg::feature_t feature_total;
	haar_pkg::feature_t leaf_word;

	// Same sign rule for every rectangle
	function automatic haar_pkg::feature_t rect_term(input haar_pkg::pixel_t a,
		input haar_pkg::pixel_t b, input haar_pkg::pixel_t c, input haar_pkg::pixel_t d,
		input logic [15:0] w);
		haar_pkg::feature_t area;
		area = haar_pkg::feature_t'(a) + haar_pkg::feature_t'(d)
			- haar_pkg::feature_t'(b) - haar_pkg::feature_t'(c);
		return area * haar_pkg::feature_t'(haar_pkg::weight_t'(w));
	endfunction

	assign accept = db.word_valid && !db.hold;
	assign db.hold = (state == haar_pkg::FETCH) || (state == haar_pkg::CALC)
		|| (state == haar_pkg::VOTE);

	//////////////////////////////
	// Corner fetch
	//////////////////////////////

	// Corner k lives at record word k + k/4, skipping the weight words
	assign rec_idx = {1'b0, fetch_idx} + {3'b000, fetch_idx[3:2]};
	assign win_raddr = haar_pkg::corner_t'(rec[rec_idx]);

	always_comb
	begin
		feat_sum = rect_term(corner_val[0], corner_val[1], corner_val[2], corner_val[3],
			rec[haar_bus_pkg::WEIGHT1]);
		feat_sum = feat_sum + rect_term(corner_val[4], corner_val[5], corner_val[6],
			corner_val[7], rec[haar_bus_pkg::WEIGHT2]);
		feat_sum = feat_sum + rect_term(corner_val[8], corner_val[9], corner_val[10],
			corner_val[11], rec[haar_bus_pkg::WEIGHT3]);
	end

	// Right word when the feature is above the tree threshold
	assign leaf_word = (feature_total >
		haar_pkg::feature_t'(haar_pkg::weight_t'(rec[haar_bus_pkg::TREE_THRESH])))
		? haar_pkg::feature_t'(haar_pkg::weight_t'(rec[haar_bus_pkg::RIGHT_WORD]))
		: haar_pkg::feature_t'(haar_pkg::weight_t'(rec[haar_bus_pkg::LEFT_WORD]));

	//////////////////////////////
	// Record and corner storage
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == haar_pkg::LOAD && accept)
		begin
			if (db.stage_word)
				stage_thr <= haar_pkg::weight_t'(db.word);
			else
				rec[db.word_pos] <= db.word;
		end
		if (state == haar_pkg::FETCH && fetch_idx != 4'd0)
			corner_val[fetch_idx - 4'd1] <= win_rdata; // Data for the previous address
		if (state == haar_pkg::CALC)
			feature_total <= feat_sum;
	end

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= haar_pkg::IDLE;
			done <= 1'b0;
			candidate <= 1'b0;
			vote_sum <= '0;
			last_tree <= 1'b0;
			fetch_idx <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				haar_pkg::IDLE:
				begin
					if (start)
					begin
						vote_sum <= '0;
						candidate <= 1'b0;
						state <= haar_pkg::LOAD;
					end
				end
				haar_pkg::LOAD:
				begin
					if (accept && db.stage_word && db.stage_last)
						state <= haar_pkg::DECIDE; // Empty stage
					else if (accept && db.tree_last)
					begin
						last_tree <= db.stage_last;
						fetch_idx <= '0;
						state <= haar_pkg::FETCH;
					end
				end
				haar_pkg::FETCH:
				begin
					fetch_idx <= fetch_idx + 4'd1;
					if (fetch_idx == 4'd12)
						state <= haar_pkg::CALC;
				end
				haar_pkg::CALC: state <= haar_pkg::VOTE;
				haar_pkg::VOTE:
				begin
					vote_sum <= vote_sum + leaf_word;
					state <= last_tree ? haar_pkg::DECIDE : haar_pkg::LOAD;
				end
				haar_pkg::DECIDE:
				begin
					candidate <= vote_sum > haar_pkg::feature_t'(stage_thr);
					done <= 1'b1;
					state <= haar_pkg::IDLE;
				end
				default: state <= haar_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* haar_detect_top.sv */
`timescale 1ns/10ps
`default_nettype none

module haar_detect_top
#(
	parameter int WIN_WIDTH = 10,
	parameter int WIN_HEIGHT = 10,
	parameter int MAX_TREES = 12
)
(
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input haar_bus_pkg::wb_addr_t wb_adr,
	input haar_bus_pkg::wb_data_t wb_dat_w,
	output haar_bus_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	output logic busy,
	output logic done,
	output logic candidate
);

	logic win_we;
	haar_pkg::corner_t win_waddr;
	haar_pkg::pixel_t win_wdata;
	haar_pkg::corner_t win_raddr;
	haar_pkg::corner_t cls_raddr;
	haar_pkg::pixel_t win_rdata;
	logic db_we;
	logic [7:0] db_waddr;
	logic [15:0] db_wdata;
	logic start;
	haar_pkg::feature_t vote_sum;

	db_haar_if db_link ();

	// Classifier owns the window read port during a run
	assign win_raddr = busy ? cls_raddr : win_waddr;

	haar_wb_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.busy(busy), .done(done), .candidate(candidate),
		.vote_sum(vote_sum), .win_rdata(win_rdata),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.win_we(win_we), .win_waddr(win_waddr), .win_wdata(win_wdata),
		.db_we(db_we), .db_waddr(db_waddr), .db_wdata(db_wdata),
		.start(start)
	);

	integral_window #(.WIN_WIDTH(WIN_WIDTH), .WIN_HEIGHT(WIN_HEIGHT)) u_window (
		.clk(clk), .we(win_we), .waddr(win_waddr), .wdata(win_wdata),
		.raddr(win_raddr), .rdata(win_rdata)
	);

	db_sequencer #(.MAX_TREES(MAX_TREES)) u_seq (
		.clk(clk), .rst_n(rst_n), .start(start),
		.db_we(db_we), .db_waddr(db_waddr), .db_wdata(db_wdata),
		.db(db_link.seq), .busy(busy)
	);

	haar_stage_classifier u_cls (
		.clk(clk), .rst_n(rst_n), .start(start),
		.db(db_link.cls),
		.win_raddr(cls_raddr), .win_rdata(win_rdata),
		.done(done), .candidate(candidate), .vote_sum(vote_sum)
	);

endmodule

`default_nettype wire

/* tb_haar_detect.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_haar_detect;

	localparam int MAX_TESTS = 8;
	localparam int MAX_TREES = 12;
	localparam int WIN_SIZE = 100;
	localparam int DB_WORDS = MAX_TREES * haar_bus_pkg::TREE_WORDS;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	haar_bus_pkg::wb_addr_t wb_adr;
	haar_bus_pkg::wb_data_t wb_dat_w;
	haar_bus_pkg::wb_data_t wb_dat_r;
	logic wb_ack;
	logic busy;
	logic done;
	logic candidate;

	int fd;
	int n_tests;
	int cycles;
	int cycle_limit;
	bit limit_set;
	int done_cycles;
	integer seed;
	logic [15:0] pix_v [MAX_TESTS][WIN_SIZE];
	logic [15:0] thr_v [MAX_TESTS];
	logic [15:0] cnt_v [MAX_TESTS];
	int nrec_v [MAX_TESTS];
	logic [15:0] word_v [MAX_TESTS][DB_WORDS];
	haar_pkg::feature_t sum_v [MAX_TESTS];
	bit cand_v [MAX_TESTS];

	haar_detect_top #(.WIN_WIDTH(10), .WIN_HEIGHT(10), .MAX_TREES(MAX_TREES)) uut (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.busy(busy), .done(done), .candidate(candidate)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog is armed once the vectors are loaded
	initial
	begin
		cycles = 0;
		while (!(limit_set && cycles > cycle_limit))
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the run did not finish", cycles);
		$display("Test failures found");
		$fatal(1);
	end

	// Counts the cycles in which done is high
	always @(negedge clk)
	begin
		if (done === 1'b1)
			done_cycles++;
	end

	//////////////////////////////
	// Failure and checks
	//////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_sum(input string name, input haar_pkg::feature_t exp,
		input haar_pkg::feature_t act);
		if (act !== exp)
			abort_run($sformatf("Mismatch at %0t: %s expected %0d, got %0d",
				$time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input bit exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Mismatch at %0t: %s expected %0b, got %0b",
				$time, name, exp, act));
	endtask

	task automatic check_pixel(input string name, input haar_pkg::pixel_t exp,
		input haar_pkg::pixel_t act);
		if (act !== exp)
			abort_run($sformatf("Mismatch at %0t: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	//////////////////////////////
	// Wishbone master
	//////////////////////////////

	// Called on a falling edge, returns on a falling edge
	task automatic bus_transfer(input bit we, input haar_bus_pkg::wb_addr_t adr,
		input haar_bus_pkg::wb_data_t wdat, output haar_bus_pkg::wb_data_t rdat);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		@(negedge clk);
		waited++;
		while (!wb_ack && waited < 4)
		begin
			@(negedge clk);
			waited++;
		end
		if (!wb_ack)
			abort_run($sformatf("No Wishbone ack within 4 cycles for address %h", adr));
		rdat = wb_dat_r; // Valid while ack is high
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
		check_flag("wb_ack", 1'b0, wb_ack); // Ack lasts a single cycle
	endtask

	task automatic wb_write(input haar_bus_pkg::wb_addr_t adr,
		input haar_bus_pkg::wb_data_t wdat);
		haar_bus_pkg::wb_data_t unused;
		bus_transfer(1'b1, adr, wdat, unused);
	endtask

	task automatic wb_read(input haar_bus_pkg::wb_addr_t adr,
		output haar_bus_pkg::wb_data_t rdat);
		bus_transfer(1'b0, adr, '0, rdat);
	endtask

	//////////////////////////////
	// Vector loading
	//////////////////////////////

	task automatic read_field(output logic [31:0] v);
		if ($fscanf(fd, " %h", v) != 1)
			abort_run("Vector file ended in the middle of a test block");
	endtask

	task automatic load_vectors();
		string line;
		logic [31:0] v;
		int code;
		int trees;
		bit at_end;
		trees = 0;
		at_end = 0;
		n_tests = 0;
		fd = $fopen("haar_vectors.txt", "r");
		if (fd == 0)
			abort_run("Cannot open haar_vectors.txt");
		code = $fgets(line, fd); // Two lines of column description
		code = $fgets(line, fd);
		while (!at_end)
		begin
			code = $fscanf(fd, " %h", v);
			if (code != 1 || n_tests == MAX_TESTS)
				at_end = 1;
			else
			begin
				pix_v[n_tests][0] = v[15:0];
				for (int i = 1; i < WIN_SIZE; i++)
				begin
					read_field(v);
					pix_v[n_tests][i] = v[15:0];
				end
				read_field(v);
				thr_v[n_tests] = v[15:0];
				read_field(v);
				cnt_v[n_tests] = v[15:0];
				read_field(v);
				nrec_v[n_tests] = v;
				if (nrec_v[n_tests] > MAX_TREES)
					abort_run("Vector block holds more tree records than fit the database");
				for (int k = 0; k < nrec_v[n_tests] * haar_bus_pkg::TREE_WORDS; k++)
				begin
					read_field(v);
					word_v[n_tests][k] = v[15:0];
				end
				read_field(v);
				sum_v[n_tests] = v;
				read_field(v);
				cand_v[n_tests] = v[0];
				// Candidate must follow sum greater than signed stage threshold
				if ((sum_v[n_tests] > haar_pkg::feature_t'(signed'(thr_v[n_tests])))
					!= cand_v[n_tests])
					abort_run($sformatf("Vector block %0d has an inconsistent candidate",
						n_tests));
				trees += nrec_v[n_tests];
				n_tests++;
			end
		end
		$fclose(fd);
		if (n_tests == 0)
			abort_run("Vector file holds no test blocks");
		cycle_limit = 200 * trees + 2000;
		limit_set = 1'b1;
	endtask

	//////////////////////////////
	// Test sequences
	//////////////////////////////

	task automatic pixel_readback();
		haar_pkg::pixel_t model [WIN_SIZE];
		bit written [WIN_SIZE];
		haar_bus_pkg::wb_data_t rd;
		int addr;
		for (int i = 0; i < WIN_SIZE; i++)
			written[i] = 1'b0;
		for (int n = 0; n < 16; n++)
		begin
			addr = $unsigned($random(seed)) % WIN_SIZE;
			model[addr] = 16'($random(seed));
			written[addr] = 1'b1;
			wb_write(haar_bus_pkg::WIN_BASE + 12'(addr), 32'(model[addr]));
		end
		for (int i = 0; i < WIN_SIZE; i++)
		begin
			if (written[i])
			begin
				wb_read(haar_bus_pkg::WIN_BASE + 12'(i), rd);
				check_pixel($sformatf("window[%0d]", i), model[i], rd[15:0]);
			end
		end
	endtask

	// Returns on the falling edge inside the done cycle
	task automatic wait_done(input bit exp_cand);
		bit seen;
		seen = 0;
		while (!seen)
		begin
			@(negedge clk);
			if (done)
				seen = 1;
			else
				check_flag("busy", 1'b1, busy); // Busy holds for the whole run
		end
		check_flag("candidate", exp_cand, candidate);
		check_flag("busy", 1'b1, busy); // Busy falls one cycle after done
	endtask

	task automatic run_block(input int t);
		haar_bus_pkg::wb_data_t rd;
		int pulses;
		for (int i = 0; i < WIN_SIZE; i++)
			wb_write(haar_bus_pkg::WIN_BASE + 12'(i), 32'(pix_v[t][i]));
		wb_write(haar_bus_pkg::DB_BASE, 32'(thr_v[t]));
		wb_write(haar_bus_pkg::DB_BASE + 12'd1, 32'(cnt_v[t]));
		for (int k = 0; k < nrec_v[t] * haar_bus_pkg::TREE_WORDS; k++)
			wb_write(haar_bus_pkg::DB_BASE + 12'd2 + 12'(k), 32'(word_v[t][k]));
		pulses = done_cycles;
		wb_write(haar_bus_pkg::REG_BASE + 12'(haar_bus_pkg::REG_CTRL), 32'd1);
		check_flag("busy", 1'b1, busy);
		wait_done(cand_v[t]);
		// This start commits at the end of the done cycle while busy is still high
		wb_write(haar_bus_pkg::REG_BASE + 12'(haar_bus_pkg::REG_CTRL), 32'd1);
		wb_read(haar_bus_pkg::REG_BASE + 12'(haar_bus_pkg::REG_STATUS), rd);
		check_flag("status.busy", 1'b0, rd[0]);
		check_flag("status.done", 1'b1, rd[1]);
		check_flag("status.candidate", cand_v[t], rd[2]);
		wb_read(haar_bus_pkg::REG_BASE + 12'(haar_bus_pkg::REG_SUM), rd);
		check_sum("vote_sum", sum_v[t], haar_pkg::feature_t'(rd));
		if (done_cycles - pulses != 1)
			abort_run($sformatf("Mismatch at %0t: done high cycles expected 1, got %0d",
				$time, done_cycles - pulses));
	endtask

	initial
	begin
		seed = 32'ha57a7a60;
		limit_set = 1'b0;
		cycle_limit = 0;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_flag("candidate", 1'b0, candidate);
		check_flag("wb_ack", 1'b0, wb_ack);
		load_vectors();
		pixel_readback();
		for (int t = 0; t < n_tests; t++)
			run_block(t);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* haar_vectors.txt */
# Per block: 100 window pixels (hex), then stage threshold, tree count word, records in file,
# then one line of 18 words per tree record, then expected vote sum and expected candidate
000 001 002 003 004 005 006 007 008 009 00a 00b 00c 00d 00e 00f 010 011 012 013
014 015 016 017 018 019 01a 01b 01c 01d 01e 01f 020 021 022 023 024 025 026 027
028 029 02a 02b 02c 02d 02e 02f 030 031 032 033 034 035 036 037 038 039 03a 03b
03c 03d 03e 03f 040 041 042 043 044 045 046 047 048 049 04a 04b 04c 04d 04e 04f
050 051 052 053 054 055 056 057 058 059 05a 05b 05c 05d 05e 05f 060 061 062 063
0009 0002 0002
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
001e 0028 0005 0001 0002 0009 0001 0001 0009 ffff 0063 0000 0000 0000 0001 0037 0003 0020
0000000a 1
000 001 002 003 004 005 006 007 008 009 00a 00b 00c 00d 00e 00f 010 011 012 013
014 015 016 017 018 019 01a 01b 01c 01d 01e 01f 020 021 022 023 024 025 026 027
028 029 02a 02b 02c 02d 02e 02f 030 031 032 033 034 035 036 037 038 039 03a 03b
03c 03d 03e 03f 040 041 042 043 044 045 046 047 048 049 04a 04b 04c 04d 04e 04f
050 051 052 053 054 055 056 057 058 059 05a 05b 05c 05d 05e 05f 060 061 062 063
000a 0002 0002
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
001e 0028 0005 0001 0002 0009 0001 0001 0009 ffff 0063 0000 0000 0000 0001 0037 0003 0020
0000000a 0
000 001 002 003 004 005 006 007 008 009 00a 00b 00c 00d 00e 00f 010 011 012 013
014 015 016 017 018 019 01a 01b 01c 01d 01e 01f 020 021 022 023 024 025 026 027
028 029 02a 02b 02c 02d 02e 02f 030 031 032 033 034 035 036 037 038 039 03a 03b
03c 03d 03e 03f 040 041 042 043 044 045 046 047 048 049 04a 04b 04c 04d 04e 04f
050 051 052 053 054 055 056 057 058 059 05a 05b 05c 05d 05e 05f 060 061 062 063
ffff 0000 0000
00000000 1
000 001 002 003 004 005 006 007 008 009 00a 00b 00c 00d 00e 00f 010 011 012 013
014 015 016 017 018 019 01a 01b 01c 01d 01e 01f 020 021 022 023 024 025 026 027
028 029 02a 02b 02c 02d 02e 02f 030 031 032 033 034 035 036 037 038 039 03a 03b
03c 03d 03e 03f 040 041 042 043 044 045 046 047 048 049 04a 04b 04c 04d 04e 04f
050 051 052 053 054 055 056 057 058 059 05a 05b 05c 05d 05e 05f 060 061 062 063
005a 000f 000c
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
0032 000a 0014 0005 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0014 0003 0007
00000054 0

/* haar_detect.f */
haar_pkg.sv
haar_bus_pkg.sv
haar_db_if.sv
haar_wb_regs.sv
integral_window.sv
db_sequencer.sv
haar_stage_classifier.sv
haar_detect_top.sv
tb_haar_detect.sv

/* Makefile */
# Verilator flow for the Haar stage detector

VERILATOR ?= verilator
TB_TOP ?= tb_haar_detect
FILELIST ?= haar_detect.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing
LINT_FLAGS ?= --lint-only
SIM_FLAGS ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR)

# A failing run ends in $$fatal, so the binary returns a failing status
sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
